// File: verilog/ipipe_defs.svh
`ifndef IPIPE_DEFS_SVH
`define IPIPE_DEFS_SVH

//////////////////////////////
// Datapath sizing
//////////////////////////////

// Operand and result width
`define IPIPE_WIDTH 32

// Architectural registers, r0 included
`define IPIPE_REGS 16

// Bits needed to name one register
`define IPIPE_RADDR 4

// ALU opcode and operand select widths
`define IPIPE_OP_W  3
`define IPIPE_SEL_W 2

`endif

// File: verilog/ipipe_pkg.sv
`include "ipipe_defs.svh"

package ipipe_pkg;

	//////////////////////////////
	// Datapath types
	//////////////////////////////

	// One operand or one result
	typedef logic [`IPIPE_WIDTH-1:0] word_t;

	// Register index
	typedef logic [`IPIPE_RADDR-1:0] reg_t;

	// ALU operations, shifts take the low five bits of operand B
	typedef enum logic [`IPIPE_OP_W-1:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7
	} alu_op_t;

	// Operand sources, operand A never takes the immediate
	typedef enum logic [`IPIPE_SEL_W-1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

endpackage

// File: verilog/ipipe_regfile.sv
`timescale 1ns/1ps
`include "ipipe_defs.svh"

module ipipe_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  ipipe_pkg::reg_t  raddr_a,
	input  ipipe_pkg::reg_t  raddr_b,
	output ipipe_pkg::word_t rdata_a,
	output ipipe_pkg::word_t rdata_b,
	input  logic             we,
	input  ipipe_pkg::reg_t  waddr,
	input  ipipe_pkg::word_t wdata
);

	// r0 has no storage, only r1 and up are real flops
	ipipe_pkg::word_t regs [1:`IPIPE_REGS-1];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `IPIPE_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			// Writes aimed at r0 fall through here and are dropped
			regs[waddr] <= wdata;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Combinational reads, r0 decodes to zero
	always_comb begin
		if (raddr_a == '0) begin
			rdata_a = '0;
		end else begin
			rdata_a = regs[raddr_a];
		end
		if (raddr_b == '0) begin
			rdata_b = '0;
		end else begin
			rdata_b = regs[raddr_b];
		end
	end

endmodule

// File: verilog/ipipe_decode.sv
`timescale 1ns/1ps

module ipipe_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                freeze,
	input  logic                issue_valid,
	input  ipipe_pkg::reg_t     issue_rd,
	input  ipipe_pkg::reg_t     issue_ra,
	input  ipipe_pkg::reg_t     issue_rb,
	input  ipipe_pkg::word_t    issue_imm,
	input  logic                issue_use_imm,
	input  ipipe_pkg::alu_op_t  issue_op,
	input  logic                ex_valid,
	input  ipipe_pkg::reg_t     ex_rd,
	input  logic                wb_valid_in,
	input  ipipe_pkg::reg_t     wb_rd_in,
	output logic                dec_valid,
	output ipipe_pkg::reg_t     dec_rd,
	output ipipe_pkg::alu_op_t  dec_op,
	output ipipe_pkg::reg_t     raddr_a,
	output ipipe_pkg::reg_t     raddr_b,
	output ipipe_pkg::word_t    dec_imm,
	output ipipe_pkg::sel_t     sel_a,
	output ipipe_pkg::sel_t     sel_b
);

	logic dec_use_imm;

	// Source select for one operand
	// Op in execute is newer than op in writeback, so it is checked first
	function automatic ipipe_pkg::sel_t fwd_sel(input ipipe_pkg::reg_t src, input logic use_imm);
		if (use_imm)
			return ipipe_pkg::SEL_IMM;
		// r0 is never forwarded, it always reads zero from the register file
		if ((src != '0) && ex_valid && (src == ex_rd))
			return ipipe_pkg::SEL_EX_FORW;
		if ((src != '0) && wb_valid_in && (src == wb_rd_in))
			return ipipe_pkg::SEL_WB_FORW;
		return ipipe_pkg::SEL_RF;
	endfunction

	//////////////////////////////
	// Decode stage register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid   <= 1'b0;
			dec_rd      <= '0;
			dec_op      <= ipipe_pkg::ALU_ADD;
			raddr_a     <= '0;
			raddr_b     <= '0;
			dec_imm     <= '0;
			dec_use_imm <= 1'b0;
		end else if (!freeze) begin
			// Issue inputs are ignored while frozen
			dec_valid   <= issue_valid;
			dec_rd      <= issue_rd;
			dec_op      <= issue_op;
			raddr_a     <= issue_ra;
			raddr_b     <= issue_rb;
			dec_imm     <= issue_imm;
			dec_use_imm <= issue_use_imm;
		end
	end

	// Selects come from the registered sources
	// Operand A has no immediate path
	always_comb begin
		sel_a = fwd_sel(raddr_a, 1'b0);
		sel_b = fwd_sel(raddr_b, dec_use_imm);
	end

endmodule

// File: verilog/ipipe_operand_muxes.sv
`timescale 1ns/1ps

module ipipe_operand_muxes (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                freeze,
	input  ipipe_pkg::word_t    rf_data_a,
	input  ipipe_pkg::word_t    rf_data_b,
	input  ipipe_pkg::word_t    ex_forw,
	input  ipipe_pkg::word_t    wb_forw,
	input  ipipe_pkg::word_t    simm,
	input  ipipe_pkg::sel_t     sel_a,
	input  ipipe_pkg::sel_t     sel_b,
	input  logic                dec_valid,
	input  ipipe_pkg::reg_t     dec_rd,
	input  ipipe_pkg::alu_op_t  dec_op,
	output ipipe_pkg::word_t    operand_a,
	output ipipe_pkg::word_t    operand_b,
	output logic                ex_valid,
	output ipipe_pkg::reg_t     ex_rd,
	output ipipe_pkg::alu_op_t  ex_op
);

	ipipe_pkg::word_t muxed_a;
	ipipe_pkg::word_t muxed_b;

	// Four-way source mux for operand B
	function automatic ipipe_pkg::word_t pick(input ipipe_pkg::sel_t sel,
		input ipipe_pkg::word_t rf, input ipipe_pkg::word_t imm,
		input ipipe_pkg::word_t exf, input ipipe_pkg::word_t wbf);
		case (sel)
			ipipe_pkg::SEL_IMM:     return imm;
			ipipe_pkg::SEL_EX_FORW: return exf;
			ipipe_pkg::SEL_WB_FORW: return wbf;
			default:                return rf;
		endcase
	endfunction

	// A has no immediate, only three sources
	always_comb begin
		case (sel_a)
			ipipe_pkg::SEL_EX_FORW: muxed_a = ex_forw;
			ipipe_pkg::SEL_WB_FORW: muxed_a = wb_forw;
			default:                muxed_a = rf_data_a;
		endcase
	end

	assign muxed_b = pick(sel_b, rf_data_b, simm, ex_forw, wb_forw);

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Operands and control hold together under freeze
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			ex_valid  <= 1'b0;
			ex_rd     <= '0;
			ex_op     <= ipipe_pkg::ALU_ADD;
		end else if (!freeze) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
			ex_valid  <= dec_valid;
			ex_rd     <= dec_rd;
			ex_op     <= dec_op;
		end
	end

endmodule

// File: verilog/ipipe_execute.sv
`timescale 1ns/1ps

module ipipe_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                freeze,
	input  ipipe_pkg::word_t    operand_a,
	input  ipipe_pkg::word_t    operand_b,
	input  logic                ex_valid,
	input  ipipe_pkg::reg_t     ex_rd,
	input  ipipe_pkg::alu_op_t  ex_op,
	output ipipe_pkg::word_t    ex_forw,
	output logic                wb_valid,
	output ipipe_pkg::reg_t     wb_rd,
	output ipipe_pkg::word_t    wb_data
);

	ipipe_pkg::word_t alu_res;
	logic [4:0]       shamt;

	// Shift amount, low five bits of B
	assign shamt = operand_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (ex_op)
			ipipe_pkg::ALU_ADD: alu_res = operand_a + operand_b;
			ipipe_pkg::ALU_SUB: alu_res = operand_a - operand_b;
			ipipe_pkg::ALU_AND: alu_res = operand_a & operand_b;
			ipipe_pkg::ALU_OR:  alu_res = operand_a | operand_b;
			ipipe_pkg::ALU_XOR: alu_res = operand_a ^ operand_b;
			ipipe_pkg::ALU_SLL: alu_res = operand_a << shamt;
			ipipe_pkg::ALU_SRL: alu_res = operand_a >> shamt;
			// Signed compare, zero extended to a full word
			ipipe_pkg::ALU_SLT: alu_res = ipipe_pkg::word_t'($signed(operand_a) < $signed(operand_b));
			default:            alu_res = '0;
		endcase
	end

	// Forwarded to decode and the operand muxes in the same cycle
	assign ex_forw = alu_res;

	//////////////////////////////
	// Writeback register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else if (!freeze) begin
			// Held under freeze, so each result is seen once on an unfrozen cycle
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
			wb_data  <= alu_res;
		end
	end

endmodule

// File: verilog/ipipe_top.sv
`timescale 1ns/1ps

module ipipe_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue_valid,
	input  ipipe_pkg::reg_t     issue_rd,
	input  ipipe_pkg::reg_t     issue_ra,
	input  ipipe_pkg::reg_t     issue_rb,
	input  ipipe_pkg::word_t    issue_imm,
	input  logic                issue_use_imm,
	input  ipipe_pkg::alu_op_t  issue_op,
	input  logic                freeze,
	output logic                wb_valid,
	output ipipe_pkg::reg_t     wb_rd,
	output ipipe_pkg::word_t    wb_data
);

	// Decode to operand stage
	logic               dec_valid;
	ipipe_pkg::reg_t    dec_rd;
	ipipe_pkg::alu_op_t dec_op;
	ipipe_pkg::reg_t    raddr_a;
	ipipe_pkg::reg_t    raddr_b;
	ipipe_pkg::word_t   dec_imm;
	ipipe_pkg::sel_t    sel_a;
	ipipe_pkg::sel_t    sel_b;
	ipipe_pkg::word_t   rf_data_a;
	ipipe_pkg::word_t   rf_data_b;

	// Operand stage to execute
	ipipe_pkg::word_t   operand_a;
	ipipe_pkg::word_t   operand_b;
	logic               ex_valid;
	ipipe_pkg::reg_t    ex_rd;
	ipipe_pkg::alu_op_t ex_op;
	ipipe_pkg::word_t   ex_forw;
	logic               rf_we;

	// No register file write while the pipeline is frozen
	assign rf_we = wb_valid & ~freeze;

	ipipe_decode u_decode (
		.clk, .rst_n, .freeze,
		.issue_valid, .issue_rd, .issue_ra, .issue_rb,
		.issue_imm, .issue_use_imm, .issue_op,
		.ex_valid, .ex_rd,
		.wb_valid_in (wb_valid), .wb_rd_in (wb_rd),
		.dec_valid, .dec_rd, .dec_op, .raddr_a, .raddr_b, .dec_imm,
		.sel_a, .sel_b
	);

	ipipe_regfile u_regfile (
		.clk, .rst_n, .raddr_a, .raddr_b,
		.rdata_a (rf_data_a), .rdata_b (rf_data_b),
		.we (rf_we), .waddr (wb_rd), .wdata (wb_data)
	);

	ipipe_operand_muxes u_operand_muxes (
		.clk, .rst_n, .freeze, .rf_data_a, .rf_data_b,
		.ex_forw, .wb_forw (wb_data), .simm (dec_imm), .sel_a, .sel_b,
		.dec_valid, .dec_rd, .dec_op,
		.operand_a, .operand_b, .ex_valid, .ex_rd, .ex_op
	);

	ipipe_execute u_execute (
		.clk, .rst_n, .freeze, .operand_a, .operand_b,
		.ex_valid, .ex_rd, .ex_op, .ex_forw, .wb_valid, .wb_rd, .wb_data
	);

endmodule

// File: tests/ipipe_properties.sv
`timescale 1ns/1ps

module ipipe_properties (
	input logic             clk,
	input logic             rst_n,
	input logic             freeze,
	input ipipe_pkg::sel_t  sel_a,
	input ipipe_pkg::word_t ex_forw,
	input ipipe_pkg::word_t operand_a,
	input ipipe_pkg::word_t operand_b,
	input logic             ex_valid
);

	//////////////////////////////
	// Operand mux checks
	//////////////////////////////

	// Execute valid feeds wb_valid, so both are quiet out of reset
	idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid)
		else $error("execute stage valid right after reset");

	// Operand A has no immediate path
	no_imm_on_a: assert property (@(posedge clk) disable iff (!rst_n)
		sel_a != ipipe_pkg::SEL_IMM)
		else $error("sel_a selects the immediate");

	// Execute forward lands in operand A one cycle later
	ex_forw_to_a: assert property (@(posedge clk) disable iff (!rst_n)
		(!freeze && sel_a == ipipe_pkg::SEL_EX_FORW) |=> operand_a == $past(ex_forw))
		else $error("operand_a misses the execute forward");

	// Frozen cycle leaves both operands alone
	hold_on_freeze: assert property (@(posedge clk) disable iff (!rst_n)
		freeze |=> ($stable(operand_a) && $stable(operand_b)))
		else $error("operands changed under freeze");

endmodule

// File: tests/ipipe_tb.sv
`timescale 1ns/1ps
`include "ipipe_defs.svh"

module ipipe_tb;

	// Operations per test, the timeout follows from their sum
	localparam int N_FIRST   = 1;
	localparam int N_CHAIN   = 40;
	localparam int N_IMM     = 40;
	localparam int N_FREEZE  = 60;
	localparam int N_ZERO    = 30;
	localparam int TOTAL_OPS = N_FIRST + N_CHAIN + N_IMM + N_FREEZE + N_ZERO;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 2 + 50;

	logic               clk;
	logic               rst_n;
	logic               issue_valid;
	ipipe_pkg::reg_t    issue_rd;
	ipipe_pkg::reg_t    issue_ra;
	ipipe_pkg::reg_t    issue_rb;
	ipipe_pkg::word_t   issue_imm;
	logic               issue_use_imm;
	ipipe_pkg::alu_op_t issue_op;
	logic               freeze;
	logic               wb_valid;
	ipipe_pkg::reg_t    wb_rd;
	ipipe_pkg::word_t   wb_data;

	// Architectural state of the model, r0 is never written
	ipipe_pkg::word_t   arch_regs [0:`IPIPE_REGS-1] = '{default: '0};
	ipipe_pkg::reg_t    exp_rd_q[$];
	ipipe_pkg::word_t   exp_data_q[$];
	ipipe_pkg::reg_t    recent [0:2];
	int                 err_count;
	int                 check_count;
	int                 cycle_count;

	ipipe_top dut0 (
		.clk, .rst_n, .issue_valid, .issue_rd, .issue_ra, .issue_rb,
		.issue_imm, .issue_use_imm, .issue_op, .freeze,
		.wb_valid, .wb_rd, .wb_data
	);

	// Operand mux assertions
	bind ipipe_operand_muxes ipipe_properties u_properties (
		.clk(clk), .rst_n(rst_n), .freeze(freeze), .sel_a(sel_a),
		.ex_forw(ex_forw), .operand_a(operand_a), .operand_b(operand_b),
		.ex_valid(ex_valid)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_word(input string name, input ipipe_pkg::word_t got,
		input ipipe_pkg::word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input ipipe_pkg::reg_t got,
		input ipipe_pkg::reg_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ALU behavior straight from the operation table
	function automatic ipipe_pkg::word_t alu_model(input ipipe_pkg::alu_op_t op,
		input ipipe_pkg::word_t a, input ipipe_pkg::word_t b);
		ipipe_pkg::word_t r;
		r = '0;
		case (op)
			ipipe_pkg::ALU_ADD: r = a + b;
			ipipe_pkg::ALU_SUB: r = a + ~b + 1;
			ipipe_pkg::ALU_AND: r = a & b;
			ipipe_pkg::ALU_OR:  r = a | b;
			ipipe_pkg::ALU_XOR: r = a ^ b;
			ipipe_pkg::ALU_SLL: r = a << b[4:0];
			ipipe_pkg::ALU_SRL: r = a >> b[4:0];
			ipipe_pkg::ALU_SLT: begin
				// Differing signs decide by sign of A, else unsigned order holds
				if (a[`IPIPE_WIDTH-1] != b[`IPIPE_WIDTH-1])
					r[0] = a[`IPIPE_WIDTH-1];
				else
					r[0] = (a < b);
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	//////////////////////////////
	// Model and result monitor
	//////////////////////////////

	// Mid-cycle sampling, inputs and outputs are both settled here
	always @(negedge clk) begin : monitor
		ipipe_pkg::word_t op_a;
		ipipe_pkg::word_t op_b;
		ipipe_pkg::word_t res;
		ipipe_pkg::reg_t  e_rd;
		ipipe_pkg::word_t e_data;
		if (rst_n) begin
			// A held result counts only on an unfrozen cycle
			if (wb_valid && !freeze) begin
				if (exp_data_q.size() == 0) begin
					err_count++;
					$display("Writeback at %0t with no operation outstanding", $time);
				end else begin
					e_rd = exp_rd_q.pop_front();
					e_data = exp_data_q.pop_front();
					check_reg("wb_rd", wb_rd, e_rd);
					check_word("wb_data", wb_data, e_data);
				end
			end
			// Issue is taken at the next edge unless frozen
			if (issue_valid && !freeze) begin
				op_a = arch_regs[issue_ra];
				op_b = issue_use_imm ? issue_imm : arch_regs[issue_rb];
				res = alu_model(issue_op, op_a, op_b);
				if (issue_rd != '0)
					arch_regs[issue_rd] = res;
				exp_rd_q.push_back(issue_rd);
				exp_data_q.push_back(res);
			end
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic drive_op(input ipipe_pkg::reg_t rd, input ipipe_pkg::reg_t ra,
		input ipipe_pkg::reg_t rb, input ipipe_pkg::word_t imm, input logic use_imm);
		issue_valid   <= 1'b1;
		issue_rd      <= rd;
		issue_ra      <= ra;
		issue_rb      <= rb;
		issue_imm     <= imm;
		issue_use_imm <= use_imm;
		issue_op      <= ipipe_pkg::alu_op_t'(3'($urandom_range(7)));
	endtask

	function automatic ipipe_pkg::reg_t rand_dest();
		return ipipe_pkg::reg_t'($urandom_range(`IPIPE_REGS-1, 1));
	endfunction

	// Shift history of the last three destinations
	task automatic note_dest(input ipipe_pkg::reg_t rd);
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = rd;
	endtask

	// Idle the inputs and wait until every result is back
	task automatic drain();
		@(posedge clk);
		issue_valid <= 1'b0;
		freeze      <= 1'b0;
		do
			@(posedge clk);
		while (exp_data_q.size() != 0);
		@(posedge clk);
	endtask

	task automatic report_test(input string name, input int ops, input int errs_before);
		$display("test %s: %0d ops, %0d errors", name, ops, err_count - errs_before);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, pipeline did not finish", cycle_count);
		$display("Testbench failed");
		$finish;
	end

	initial begin : run
		int errs;
		int issued;
		ipipe_pkg::reg_t rd;
		ipipe_pkg::reg_t ra;
		ipipe_pkg::reg_t rb;
		clk           = 1'b0;
		rst_n         = 1'b0;
		issue_valid   = 1'b0;
		issue_rd      = '0;
		issue_ra      = '0;
		issue_rb      = '0;
		issue_imm     = '0;
		issue_use_imm = 1'b0;
		issue_op      = ipipe_pkg::ALU_ADD;
		freeze        = 1'b0;
		err_count     = 0;
		check_count   = 0;
		cycle_count   = 0;
		recent        = '{default: '0};
		void'($urandom(47));
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// 1: quiet pipeline after reset, then one op through
		errs = err_count;
		repeat (6) begin
			@(negedge clk);
			check_flag("wb_valid", wb_valid, 1'b0);
		end
		@(posedge clk);
		drive_op(4'd1, 4'd0, 4'd0, ipipe_pkg::word_t'($urandom), 1'b1);
		note_dest(4'd1);
		drain();
		report_test("reset_idle", N_FIRST, errs);

		// 2: dependent chain, sources from the last three results
		errs = err_count;
		for (int i = 0; i < N_CHAIN; i++) begin
			@(posedge clk);
			rd = rand_dest();
			ra = recent[$urandom_range(2)];
			rb = recent[$urandom_range(2)];
			drive_op(rd, ra, rb, ipipe_pkg::word_t'($urandom), ($urandom_range(3) == 0));
			note_dest(rd);
		end
		drain();
		report_test("dependent_chain", N_CHAIN, errs);

		// 3: immediate operand B
		errs = err_count;
		for (int i = 0; i < N_IMM; i++) begin
			@(posedge clk);
			rd = rand_dest();
			ra = recent[$urandom_range(2)];
			drive_op(rd, ra, rand_dest(), ipipe_pkg::word_t'($urandom), 1'b1);
			note_dest(rd);
		end
		drain();
		report_test("immediate_ops", N_IMM, errs);

		// 4: random freeze and gaps, junk issue while frozen
		errs = err_count;
		issued = 0;
		while (issued < N_FREEZE) begin
			@(posedge clk);
			if ($urandom_range(3) == 0) begin
				freeze <= 1'b1;
				drive_op(rand_dest(), rand_dest(), rand_dest(),
					ipipe_pkg::word_t'($urandom), 1'b0);
			end else begin
				freeze <= 1'b0;
				if ($urandom_range(3) == 0) begin
					issue_valid <= 1'b0;
				end else begin
					rd = rand_dest();
					ra = recent[$urandom_range(2)];
					rb = recent[$urandom_range(2)];
					drive_op(rd, ra, rb, ipipe_pkg::word_t'($urandom),
						($urandom_range(3) == 0));
					note_dest(rd);
					issued++;
				end
			end
		end
		drain();
		report_test("freeze_gaps", N_FREEZE, errs);

		// 5: r0 as source and as destination
		errs = err_count;
		for (int i = 0; i < N_ZERO; i++) begin
			@(posedge clk);
			rd = ($urandom_range(2) == 0) ? 4'd0 : rand_dest();
			ra = ($urandom_range(1) == 0) ? 4'd0 : recent[$urandom_range(2)];
			rb = ($urandom_range(1) == 0) ? 4'd0 : recent[$urandom_range(2)];
			drive_op(rd, ra, rb, ipipe_pkg::word_t'($urandom), ($urandom_range(3) == 0));
			note_dest(rd);
		end
		drain();
		report_test("register_zero", N_ZERO, errs);

		if (exp_data_q.size() != 0) begin
			err_count++;
			$display("%0d results never came back", exp_data_q.size());
		end
		$display("tests 5, checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/ipipe_pkg.sv
verilog/ipipe_regfile.sv
verilog/ipipe_decode.sv
verilog/ipipe_operand_muxes.sv
verilog/ipipe_execute.sv
verilog/ipipe_top.sv
tests/ipipe_properties.sv
tests/ipipe_tb.sv

// File: Makefile
# Verilator flow for the execute pipeline

VERILATOR ?= verilator
TOP       ?= ipipe_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# A stopped run leaves no pass line, so both searches are needed
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "sim: FAIL, no result line"; exit 1; fi
	@echo "sim: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
